/* source/mem_map_pkg.sv */
//////////////////////////////////////////////////
// Memory map of the cabinet SDRAM
// Region bases, download indices and CPU address types
//////////////////////////////////////////////////

package mem_map_pkg;

	// Download side
	localparam int DL_ADDR_W = 25;	// Byte address from the loader

	// SDRAM side, 16-bit words
	localparam int MEM_ADDR_W = 23;

	// Byte bases of the ROM regions inside the download image
	localparam logic [31:0] SND_BASE  = 32'h0002_3000;
	localparam logic [31:0] SND2_BASE = 32'h0003_5000;	// Speech board ROMs

	// Graphics sit on port 2 and start at word zero there
	localparam logic [31:0] GFX_BASE  = 32'h0002_5000;

	// Loader index codes
	localparam logic [7:0] ROM_INDEX   = 8'h00;
	localparam logic [7:0] NVRAM_INDEX = 8'hff;	// CMOS save image

	// CPU byte addresses as seen on the fetch ports
	typedef logic [17:0] main_addr_t;
	typedef logic [12:0] snd_addr_t;
	typedef logic [16:0] snd2_addr_t;

endpackage

/* source/cabinet_pkg.sv */
//////////////////////////////////////////////////
// Cabinet definitions
// Game select codes and player button layout
//////////////////////////////////////////////////

package cabinet_pkg;

	// Board variant, selects the control panel wiring
	typedef enum logic [1:0] {
		GAME_TSHOOT  = 2'd0,
		GAME_JOUST2  = 2'd1,
		GAME_INFERNO = 2'd2,
		GAME_MYSTICM = 2'd3
	} game_t;

	// One player's buttons, active high
	typedef logic [13:0] player_t;

	// Bit positions inside player_t
	localparam int BTN_RIGHT   = 0;
	localparam int BTN_LEFT    = 1;
	localparam int BTN_DOWN    = 2;
	localparam int BTN_UP      = 3;
	localparam int BTN_FIRE_A  = 4;
	localparam int BTN_FIRE_B  = 5;
	localparam int BTN_FIRE_C  = 6;
	localparam int BTN_FIRE_D  = 7;
	localparam int BTN_FIRE_E  = 8;
	localparam int BTN_FIRE_F  = 9;
	// Second stick, Inferno fire directions
	localparam int BTN_RIGHT_B = 10;
	localparam int BTN_LEFT_B  = 11;
	localparam int BTN_DOWN_B  = 12;
	localparam int BTN_UP_B    = 13;

endpackage

/* source/download_ctrl.sv */
//////////////////////////////////////////////////
// ROM download writer and core reset sequencer
// Toggles SDRAM write requests per loader byte
//////////////////////////////////////////////////
`timescale 1ns/1ps

module download_ctrl (
	input  logic                               clk_mem,
	input  logic                               reset_i,
	input  logic                               dl_active_i,
	input  logic [7:0]                         dl_index_i,
	input  logic [mem_map_pkg::DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [7:0]                         dl_data_i,
	input  logic                               dl_wr_i,
	input  logic                               user_reset_i,
	output logic                               port1_req_o,
	output logic                               port2_req_o,
	output logic [mem_map_pkg::MEM_ADDR_W-1:0] port1_addr_o,
	output logic [mem_map_pkg::MEM_ADDR_W-1:0] port2_addr_o,
	output logic [1:0]                         port1_be_o,
	output logic [1:0]                         port2_be_o,
	output logic [15:0]                        port_data_o,
	output logic                               rom_wr_o,
	output logic                               nvram_wr_o,
	output logic                               rom_download_o,
	output logic                               core_reset_o
);

	logic [mem_map_pkg::DL_ADDR_W-1:0] gfx_addr;
	logic                              dl_active_d;
	logic                              loaded;

	assign rom_download_o = dl_active_i & (dl_index_i == mem_map_pkg::ROM_INDEX);

	// Graphics port counts from the start of the graphics region
	assign gfx_addr = dl_addr_i - mem_map_pkg::GFX_BASE[mem_map_pkg::DL_ADDR_W-1:0];

	assign port1_addr_o = dl_addr_i[mem_map_pkg::MEM_ADDR_W:1];
	assign port2_addr_o = gfx_addr[mem_map_pkg::MEM_ADDR_W:1];
	assign port1_be_o   = {dl_addr_i[0], ~dl_addr_i[0]};	// Odd byte goes high
	assign port2_be_o   = {gfx_addr[0], ~gfx_addr[0]};
	assign port_data_o  = {dl_data_i, dl_data_i};

	assign rom_wr_o   = dl_wr_i & (dl_index_i == mem_map_pkg::ROM_INDEX);
	assign nvram_wr_o = dl_wr_i & (dl_index_i == mem_map_pkg::NVRAM_INDEX);

	always_ff @(posedge clk_mem) begin
		if (reset_i) begin
			port1_req_o  <= 1'b0;
			port2_req_o  <= 1'b0;
			dl_active_d  <= 1'b0;
			loaded       <= 1'b0;
			core_reset_o <= 1'b1;
		end else begin
			// A flipped toggle is a new SDRAM write
			if (dl_wr_i && rom_download_o) begin
				port1_req_o <= ~port1_req_o;
				port2_req_o <= ~port2_req_o;
			end
			dl_active_d <= dl_active_i;
			if (dl_active_d && !dl_active_i) loaded <= 1'b1;	// Download just ended
			core_reset_o <= user_reset_i | dl_active_i | ~loaded;
		end
	end

endmodule

/* source/fetch_port.sv */
//////////////////////////////////////////////////
// CPU fetch port into the shared ROM SDRAM
// Region offset, word address register, byte lane select
//////////////////////////////////////////////////
`timescale 1ns/1ps

module fetch_port #(
	parameter type         addr_t = logic [17:0],
	parameter logic [31:0] BASE   = 32'h0
) (
	input  logic                               clk_mem,
	input  logic                               rom_download_i,
	input  addr_t                              cpu_addr_i,
	input  logic [15:0]                        word_i,
	output logic [mem_map_pkg::MEM_ADDR_W-1:0] mem_addr_o,
	output logic [7:0]                         byte_o
);

	localparam int AW = $bits(addr_t);

	// Byte address inside the SDRAM, one bit wider than the word address
	logic [mem_map_pkg::MEM_ADDR_W:0] byte_addr;

	assign byte_addr = {{(mem_map_pkg::MEM_ADDR_W + 1 - AW){1'b0}}, cpu_addr_i}
		+ BASE[mem_map_pkg::MEM_ADDR_W:0];

	// Loader owns the memory while a ROM comes in
	always_ff @(posedge clk_mem) begin
		mem_addr_o <= rom_download_i ? '0 : byte_addr[mem_map_pkg::MEM_ADDR_W:1];
	end

	assign byte_o = cpu_addr_i[0] ? word_i[15:8] : word_i[7:0];

endmodule

/* source/panel_pulse.sv */
//////////////////////////////////////////////////
// Panel button pulse stretcher
//////////////////////////////////////////////////
`timescale 1ns/1ps

module panel_pulse #(
	parameter int STRETCH_CYCLES = 'hfffff
) (
	input  logic clk_mem,
	input  logic reset_i,
	input  logic btn_i,
	output logic pulse_o
);

	localparam int CNT_W = $clog2(STRETCH_CYCLES + 1);

	logic             btn_d;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clk_mem) begin
		if (reset_i) begin
			btn_d <= 1'b0;
			count <= '0;
		end else begin
			btn_d <= btn_i;
			if (btn_i && !btn_d) begin
				count <= CNT_W'(STRETCH_CYCLES);	// Restarts a running pulse too
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
		end
	end

	assign pulse_o = (count != '0);

endmodule

/* source/control_mapper.sv */
//////////////////////////////////////////////////
// Control panel mapper
// Player buttons onto the two game input bytes
//////////////////////////////////////////////////
`timescale 1ns/1ps

module control_mapper (
	input  cabinet_pkg::game_t   game_i,
	input  cabinet_pkg::player_t p1_i,
	input  cabinet_pkg::player_t p2_i,
	input  logic                 start1_i,
	input  logic                 start2_i,
	input  logic                 coin1_i,
	input  logic                 coin2_i,
	input  logic                 input_sel_i,
	output logic [7:0]           input1_o,
	output logic [7:0]           input2_o,
	output logic                 coin_o
);

	cabinet_pkg::player_t sel;	// Player picked by the board's mux line
	cabinet_pkg::player_t both;

	assign sel    = input_sel_i ? p2_i : p1_i;
	assign both   = p1_i | p2_i;
	assign coin_o = coin1_i | coin2_i;

	always_comb begin
		input1_o = 8'h00;
		input2_o = 8'h00;

		case (game_i)
			cabinet_pkg::GAME_TSHOOT: begin
				// Gun position bits stay zero without a gun
				input1_o[7] = ~both[cabinet_pkg::BTN_FIRE_A];
				input2_o = {start2_i, start1_i, 4'b0000,
					both[cabinet_pkg::BTN_FIRE_C], both[cabinet_pkg::BTN_FIRE_B]};
			end
			cabinet_pkg::GAME_JOUST2: begin
				input1_o[7:4] = {2'b11, ~p1_i[cabinet_pkg::BTN_FIRE_B],
					~p2_i[cabinet_pkg::BTN_FIRE_B]};
				input1_o[3:0] = ~{1'b0, sel[cabinet_pkg::BTN_FIRE_A],
					sel[cabinet_pkg::BTN_RIGHT], sel[cabinet_pkg::BTN_LEFT]};
			end
			cabinet_pkg::GAME_INFERNO: begin
				// Second stick shares lines with the extra fire buttons
				input1_o = ~{
					sel[cabinet_pkg::BTN_DOWN_B]  | sel[cabinet_pkg::BTN_FIRE_E],
					sel[cabinet_pkg::BTN_RIGHT_B] | sel[cabinet_pkg::BTN_FIRE_D],
					sel[cabinet_pkg::BTN_LEFT_B]  | sel[cabinet_pkg::BTN_FIRE_C],
					sel[cabinet_pkg::BTN_UP_B]    | sel[cabinet_pkg::BTN_FIRE_B],
					sel[cabinet_pkg::BTN_DOWN],
					sel[cabinet_pkg::BTN_RIGHT],
					sel[cabinet_pkg::BTN_LEFT],
					sel[cabinet_pkg::BTN_UP]
				};
				input2_o = {start2_i, start1_i, 4'b0000,
					p2_i[cabinet_pkg::BTN_FIRE_A], p1_i[cabinet_pkg::BTN_FIRE_A]};
			end
			cabinet_pkg::GAME_MYSTICM: begin
				input1_o = {p1_i[cabinet_pkg::BTN_FIRE_A], 1'b0, start2_i, start1_i,
					p1_i[cabinet_pkg::BTN_LEFT], p1_i[cabinet_pkg::BTN_DOWN],
					p1_i[cabinet_pkg::BTN_RIGHT], p1_i[cabinet_pkg::BTN_UP]};
			end
			default: begin
				input1_o = 8'h00;
				input2_o = 8'h00;
			end
		endcase
	end

endmodule

/* source/williams2_mem_top.sv */
//////////////////////////////////////////////////
// Williams gen 2 memory side top level
// Download writer, fetch ports, panel pulses, controls
//////////////////////////////////////////////////
`timescale 1ns/1ps

module williams2_mem_top #(
	parameter int STRETCH_CYCLES = 'hfffff
) (
	input  logic                               clk_mem,
	input  logic                               reset_i,
	input  logic                               dl_active_i,
	input  logic [7:0]                         dl_index_i,
	input  logic [mem_map_pkg::DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [7:0]                         dl_data_i,
	input  logic                               dl_wr_i,
	input  logic                               user_reset_i,
	output logic                               port1_req_o,
	output logic                               port2_req_o,
	output logic [mem_map_pkg::MEM_ADDR_W-1:0] port1_addr_o,
	output logic [mem_map_pkg::MEM_ADDR_W-1:0] port2_addr_o,
	output logic [1:0]                         port1_be_o,
	output logic [1:0]                         port2_be_o,
	output logic [15:0]                        port_data_o,
	output logic                               rom_wr_o,
	output logic                               nvram_wr_o,
	output logic                               core_reset_o,
	input  mem_map_pkg::main_addr_t            main_addr_i,
	input  mem_map_pkg::snd_addr_t             snd_addr_i,
	input  mem_map_pkg::snd2_addr_t            snd2_addr_i,
	input  logic [15:0]                        main_word_i,
	input  logic [15:0]                        snd_word_i,
	input  logic [15:0]                        snd2_word_i,
	output logic [mem_map_pkg::MEM_ADDR_W-1:0] main_mem_addr_o,
	output logic [mem_map_pkg::MEM_ADDR_W-1:0] snd_mem_addr_o,
	output logic [mem_map_pkg::MEM_ADDR_W-1:0] snd2_mem_addr_o,
	output logic [7:0]                         main_byte_o,
	output logic [7:0]                         snd_byte_o,
	output logic [7:0]                         snd2_byte_o,
	input  logic                               adv_btn_i,
	input  logic                               hsr_btn_i,
	output logic                               advance_o,
	output logic                               hs_reset_o,
	input  cabinet_pkg::game_t                 game_i,
	input  cabinet_pkg::player_t               p1_i,
	input  cabinet_pkg::player_t               p2_i,
	input  logic                               start1_i,
	input  logic                               start2_i,
	input  logic                               coin1_i,
	input  logic                               coin2_i,
	input  logic                               input_sel_i,
	output logic [7:0]                         input1_o,
	output logic [7:0]                         input2_o,
	output logic                               coin_o
);

	logic rom_download;	// Parks all fetch ports at zero

	download_ctrl u_download_ctrl (
		.clk_mem        (clk_mem),
		.reset_i        (reset_i),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.dl_wr_i        (dl_wr_i),
		.user_reset_i   (user_reset_i),
		.port1_req_o    (port1_req_o),
		.port2_req_o    (port2_req_o),
		.port1_addr_o   (port1_addr_o),
		.port2_addr_o   (port2_addr_o),
		.port1_be_o     (port1_be_o),
		.port2_be_o     (port2_be_o),
		.port_data_o    (port_data_o),
		.rom_wr_o       (rom_wr_o),
		.nvram_wr_o     (nvram_wr_o),
		.rom_download_o (rom_download),
		.core_reset_o   (core_reset_o)
	);

	// Main CPU program ROM starts at byte zero
	fetch_port #(.addr_t(mem_map_pkg::main_addr_t), .BASE(32'h0)) u_main_port (
		.clk_mem        (clk_mem),
		.rom_download_i (rom_download),
		.cpu_addr_i     (main_addr_i),
		.word_i         (main_word_i),
		.mem_addr_o     (main_mem_addr_o),
		.byte_o         (main_byte_o)
	);

	fetch_port #(.addr_t(mem_map_pkg::snd_addr_t), .BASE(mem_map_pkg::SND_BASE)) u_snd_port (
		.clk_mem        (clk_mem),
		.rom_download_i (rom_download),
		.cpu_addr_i     (snd_addr_i),
		.word_i         (snd_word_i),
		.mem_addr_o     (snd_mem_addr_o),
		.byte_o         (snd_byte_o)
	);

	fetch_port #(
		.addr_t (mem_map_pkg::snd2_addr_t),
		.BASE   (mem_map_pkg::SND2_BASE)
	) u_snd2_port (
		.clk_mem        (clk_mem),
		.rom_download_i (rom_download),
		.cpu_addr_i     (snd2_addr_i),
		.word_i         (snd2_word_i),
		.mem_addr_o     (snd2_mem_addr_o),
		.byte_o         (snd2_byte_o)
	);

	panel_pulse #(.STRETCH_CYCLES(STRETCH_CYCLES)) u_advance (
		.clk_mem (clk_mem),
		.reset_i (reset_i),
		.btn_i   (adv_btn_i),
		.pulse_o (advance_o)
	);

	panel_pulse #(.STRETCH_CYCLES(STRETCH_CYCLES)) u_hs_reset (
		.clk_mem (clk_mem),
		.reset_i (reset_i),
		.btn_i   (hsr_btn_i),
		.pulse_o (hs_reset_o)
	);

	control_mapper u_control_mapper (
		.game_i      (game_i),
		.p1_i        (p1_i),
		.p2_i        (p2_i),
		.start1_i    (start1_i),
		.start2_i    (start2_i),
		.coin1_i     (coin1_i),
		.coin2_i     (coin2_i),
		.input_sel_i (input_sel_i),
		.input1_o    (input1_o),
		.input2_o    (input2_o),
		.coin_o      (coin_o)
	);

endmodule

/* tb/tb_williams2_mem.sv */
//////////////////////////////////////////////////
// Testbench for the Williams gen 2 memory side
// Reads cases from a file, plays the SDRAM, checks
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_williams2_mem;

	localparam int CLK_PERIOD  = 40;
	localparam int MAX_CASES   = 32;
	localparam int CASE_CYCLES = 200;

	logic clk_mem = 1'b0;
	logic reset_i;
	logic dl_active_i, dl_wr_i, user_reset_i;
	logic [7:0] dl_index_i, dl_data_i;
	logic [mem_map_pkg::DL_ADDR_W-1:0] dl_addr_i;
	logic port1_req_o, port2_req_o, rom_wr_o, nvram_wr_o, core_reset_o;
	logic [mem_map_pkg::MEM_ADDR_W-1:0] port1_addr_o, port2_addr_o;
	logic [1:0] port1_be_o, port2_be_o;
	logic [15:0] port_data_o;
	mem_map_pkg::main_addr_t main_addr_i;
	mem_map_pkg::snd_addr_t snd_addr_i;
	mem_map_pkg::snd2_addr_t snd2_addr_i;
	logic [15:0] main_word_i, snd_word_i, snd2_word_i;
	logic [mem_map_pkg::MEM_ADDR_W-1:0] main_mem_addr_o, snd_mem_addr_o, snd2_mem_addr_o;
	logic [7:0] main_byte_o, snd_byte_o, snd2_byte_o;
	logic adv_btn_i, hsr_btn_i, advance_o, hs_reset_o;
	cabinet_pkg::game_t game_i;
	cabinet_pkg::player_t p1_i, p2_i;
	logic start1_i, start2_i, coin1_i, coin2_i, input_sel_i;
	logic [7:0] input1_o, input2_o;
	logic coin_o;

	logic [127:0] cases [MAX_CASES];	// kind, arg0, arg1, expected
	int ncases = 0;
	int errors = 0;
	int seed = 32'h33ca_2fc8;

	williams2_mem_top #(.STRETCH_CYCLES(16)) u_dut (.*);

	always #(CLK_PERIOD / 2) clk_mem = ~clk_mem;

	// SDRAM model, pattern spans the whole word address
	function automatic logic [15:0] mem_word(input logic [22:0] a);
		return a[15:0] ^ {a[22:16], 9'h000} ^ 16'hc3a5;
	endfunction

	assign main_word_i = mem_word(main_mem_addr_o);
	assign snd_word_i  = mem_word(snd_mem_addr_o);
	assign snd2_word_i = mem_word(snd2_mem_addr_o);

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic logic [31:0] fetch_mem_addr(input int region);
		return (region == 0) ? main_mem_addr_o : (region == 1) ? snd_mem_addr_o
			: snd2_mem_addr_o;
	endfunction

	// Tasks below start and end 2 ns after a rising edge
	task automatic run_reset_seq(input int dl_cycles, input int exp_latency);
		int n;
		n = 0;
		check_hex("core_reset_o", core_reset_o, 1);
		dl_active_i = 1'b1;
		dl_index_i  = mem_map_pkg::ROM_INDEX;
		repeat (dl_cycles) @(posedge clk_mem);
		#1 check_hex("core_reset_o", core_reset_o, 1);
		#1 dl_active_i = 1'b0;
		while (n < 20) begin
			@(posedge clk_mem);
			#1 n++;
			if (core_reset_o == 1'b0) break;
			#1;
		end
		check_hex("core_reset latency", n, exp_latency);
		#1 user_reset_i = 1'b1;
		@(posedge clk_mem);
		#1 check_hex("core_reset_o", core_reset_o, 1);
		#1 user_reset_i = 1'b0;
		@(posedge clk_mem);
		#1 check_hex("core_reset_o", core_reset_o, 0);
		#1;
	endtask

	task automatic run_dl_write(input logic [7:0] idx, input logic [31:0] a, input logic [7:0] d,
			input logic [31:0] exp2);
		logic r1, r2;
		logic is_rom;
		is_rom = (idx == mem_map_pkg::ROM_INDEX);
		dl_active_i = 1'b1;
		dl_index_i  = idx;
		dl_addr_i   = a[mem_map_pkg::DL_ADDR_W-1:0];
		dl_data_i   = d;
		dl_wr_i     = 1'b1;
		#1;
		r1 = port1_req_o;
		r2 = port2_req_o;
		check_hex("rom_wr_o", rom_wr_o, is_rom);
		check_hex("nvram_wr_o", nvram_wr_o, !is_rom);
		if (is_rom) begin
			check_hex("port1_addr_o", port1_addr_o, a[23:1]);
			check_hex("port2_addr_o", port2_addr_o, exp2);
			check_hex("port1_be_o", port1_be_o, a[0] ? 2'b10 : 2'b01);
			check_hex("port2_be_o", port2_be_o, a[0] ? 2'b10 : 2'b01);
			check_hex("port_data_o", port_data_o, {d, d});
		end
		@(posedge clk_mem);
		#1 check_hex("port1_req_o", port1_req_o, is_rom ? !r1 : r1);
		check_hex("port2_req_o", port2_req_o, is_rom ? !r2 : r2);
		#1 dl_wr_i = 1'b0;
		dl_active_i = 1'b0;
	endtask

	task automatic run_fetch(input int region, input logic [31:0] a, input logic [31:0] exp);
		logic [31:0] base;
		logic [31:0] got_addr, got_byte, a2, want, held;
		logic [15:0] w;
		base = (region == 0) ? 32'h0 : (region == 1) ? mem_map_pkg::SND_BASE
			: mem_map_pkg::SND2_BASE;
		held = 32'h0;
		for (int step = 0; step < 3; step++) begin
			a2 = a + step;
			dl_active_i = (step == 2);	// Third beat during a ROM download
			dl_index_i  = mem_map_pkg::ROM_INDEX;
			case (region)
				0: main_addr_i = a2;
				1: snd_addr_i  = a2;
				default: snd2_addr_i = a2;
			endcase
			if (step == 0) want = exp;
			else if (step == 1) want = (a2 + base) >> 1;
			else want = 32'h0;
			// Register still shows the previous beat before the edge
			#1;
			if (step > 0) check_hex("mem_addr_o", fetch_mem_addr(region), held);
			@(posedge clk_mem);
			#1;
			got_addr = fetch_mem_addr(region);
			got_byte = (region == 0) ? main_byte_o : (region == 1) ? snd_byte_o : snd2_byte_o;
			w = mem_word(got_addr);
			check_hex("mem_addr_o", got_addr, want);
			check_hex("byte_o", got_byte, a2[0] ? w[15:8] : w[7:0]);
			held = want;
			#1;
		end
		dl_active_i = 1'b0;
	endtask

	task automatic run_panel(input int which, input int second_at, input int exp_high);
		int highs;
		highs = 0;
		if (which == 0) adv_btn_i = 1'b1;
		else hsr_btn_i = 1'b1;
		for (int i = 1; i <= 60; i++) begin
			@(posedge clk_mem);
			#1 highs += (which == 0) ? advance_o : hs_reset_o;
			#1;
			if (which == 0) adv_btn_i = (second_at != 0 && i == second_at);
			else hsr_btn_i = (second_at != 0 && i == second_at);
		end
		check_hex("pulse high cycles", highs, exp_high);
	endtask

	// Expected {coin, input1, input2} from the panel wiring rules
	function automatic logic [16:0] map_expect(input logic [1:0] g, input logic [13:0] a,
			input logic [13:0] b, input logic s1, input logic s2, input logic c, input logic sel);
		logic [13:0] p;
		logic [7:0] i1, i2;
		p  = sel ? b : a;
		i1 = 8'h00;
		i2 = 8'h00;
		if (g == 0) begin
			i1[7] = !(a[4] | b[4]);
			i2 = {s2, s1, 4'b0, a[6] | b[6], a[5] | b[5]};
		end else if (g == 1) begin
			i1 = {2'b11, !a[5], !b[5], 1'b1, !p[4], !p[0], !p[1]};
		end else if (g == 2) begin
			i1 = ~{p[12] | p[8], p[10] | p[7], p[11] | p[6], p[13] | p[5], p[2], p[0], p[1], p[3]};
			i2 = {s2, s1, 4'b0, b[4], a[4]};
		end else begin
			i1 = {a[4], 1'b0, s2, s1, a[1], a[2], a[0], a[3]};
		end
		return {c, i1, i2};
	endfunction

	task automatic run_mapper(input int iters);
		logic [16:0] exp;
		for (int it = 0; it < iters; it++) begin
			for (int g = 0; g < 4; g++) begin
				for (int s = 0; s < 2; s++) begin
					p1_i = $random(seed);
					p2_i = $random(seed);
					{start1_i, start2_i, coin1_i, coin2_i} = $random(seed);
					game_i = cabinet_pkg::game_t'(g);
					input_sel_i = s;
					#1;
					exp = map_expect(g, p1_i, p2_i, start1_i, start2_i, coin1_i | coin2_i, s);
					check_hex("input1_o", input1_o, exp[15:8]);
					check_hex("input2_o", input2_o, exp[7:0]);
					check_hex("coin_o", coin_o, exp[16]);
					@(posedge clk_mem);
					#2;
				end
			end
		end
	endtask

	initial begin
		int err_before;
		logic [31:0] kind, arg0, arg1, exp;
		reset_i = 1'b1;
		{dl_active_i, dl_wr_i, user_reset_i, adv_btn_i, hsr_btn_i} = '0;
		dl_index_i = 8'h00;
		dl_data_i  = 8'h00;
		dl_addr_i  = '0;
		{main_addr_i, snd_addr_i, snd2_addr_i} = '0;
		game_i = cabinet_pkg::GAME_TSHOOT;
		{p1_i, p2_i} = '0;
		{start1_i, start2_i, coin1_i, coin2_i, input_sel_i} = '0;
		for (int i = 0; i < MAX_CASES; i++) cases[i] = '0;
		$readmemh("tb/williams2_cases.txt", cases);
		while (ncases < MAX_CASES && cases[ncases][127:96] != 0) ncases++;
		if (ncases == 0) begin
			$display("No cases were read from the case file");
			errors++;
		end
		repeat (10) @(posedge clk_mem);
		#2 reset_i = 1'b0;
		// State left behind by reset
		check_hex("port1_req_o", port1_req_o, 0);
		check_hex("port2_req_o", port2_req_o, 0);
		check_hex("advance_o", advance_o, 0);
		check_hex("hs_reset_o", hs_reset_o, 0);
		for (int i = 0; i < ncases; i++) begin
			{kind, arg0, arg1, exp} = cases[i];
			err_before = errors;
			case (kind)
				1: run_dl_write(mem_map_pkg::ROM_INDEX, arg0, arg1, exp);
				2: run_dl_write(mem_map_pkg::NVRAM_INDEX, arg0, arg1, exp);
				3: run_reset_seq(arg0, exp);
				4: run_fetch(arg0, arg1, exp);
				5: run_panel(arg0, arg1, exp);
				6: run_mapper(arg0);
				default: begin
					$display("Case %0d has an unknown kind %0d", i, kind);
					errors++;
				end
			endcase
			$display("case %0d kind %0d: %s", i, kind, (errors == err_before) ? "ok" : "FAILED");
		end
		$display("%0d cases run, %0d checks failed", ncases, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Watchdog sized from the number of cases
	initial begin
		wait (reset_i === 1'b0);
		#(ncases * CASE_CYCLES * CLK_PERIOD + 20 * CLK_PERIOD);
		$display("Run timed out before all cases finished");
		$display("test failed");
		$finish;
	end

endmodule

/* tb/williams2_cases.txt */
// Columns: kind, arg0, arg1, expected (8 hex digits each)
// 1 ROM write addr data port2_addr, 2 NVRAM write, 3 reset seq, 4 fetch, 5 panel, 6 mapper
00000003_00000008_00000000_00000002
00000001_00025000_000000a5_00000000
00000001_00000123_0000003c_007ed891
00000001_00025101_00000077_00000080
00000001_0003ffff_000000e1_0000d7ff
00000002_00000010_00000099_00000000
00000004_00000000_00000101_00000080
00000004_00000000_0003fff0_0001fff8
00000004_00000001_00000123_00011891
00000004_00000001_00001ffe_000127ff
00000004_00000002_0001fff0_0002a7f8
00000004_00000002_00000011_0001a808
00000005_00000000_00000000_00000010
00000005_00000001_00000000_00000010
00000005_00000000_00000006_00000016
00000005_00000001_0000000a_0000001a
00000006_00000028_00000000_00000000

/* verilog.f */
source/mem_map_pkg.sv
source/cabinet_pkg.sv
source/download_ctrl.sv
source/fetch_port.sv
source/panel_pulse.sv
source/control_mapper.sv
source/williams2_mem_top.sv
tb/tb_williams2_mem.sv

/* Bender.yml */
package:
  name: williams2_mem

sources:
  - files:
      - source/mem_map_pkg.sv
      - source/cabinet_pkg.sv
      - source/download_ctrl.sv
      - source/fetch_port.sv
      - source/panel_pulse.sv
      - source/control_mapper.sv
      - source/williams2_mem_top.sv
  - target: test
    files:
      - tb/tb_williams2_mem.sv
